//--- compile.f
+incdir+common
common/rename_pkg.sv
common/reg_query_if.sv
renamer/renamer.sv
renamer/rename_table.sv
renamer/free_list.sv
design/rename_unit.sv
bench/rename_tb.sv

//--- Bender.yml
package:
  name: rename_unit

sources:
  - include_dirs:
      - common
    files:
      - common/rename_pkg.sv
      - common/reg_query_if.sv
      - renamer/renamer.sv
      - renamer/rename_table.sv
      - renamer/free_list.sv
      - design/rename_unit.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/rename_tb.sv

//--- bench/rename_tb.sv
`include "rename_params.svh"

module rename_tb import rename_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum int {M_RENAME, M_DEP, M_JUMP, M_RANDOM} mode_e;

  localparam int RENAME_N  = 10;
  localparam int EXHAUST_N = 40;
  localparam int RECYCLE_N = 60;
  localparam int DEP_N     = 120;
  localparam int JUMP_N    = 120;
  localparam int STALL_N   = 120;
  localparam int RANDOM_N  = 280;
  localparam int WATCHDOG_CYCLES = 4 * (RENAME_N + EXHAUST_N + RECYCLE_N + DEP_N + JUMP_N +
                                        STALL_N + RANDOM_N);

  logic           global_bus = 1'b0;
  logic           rst;
  instr_info_t    instr_in [2];
  logic [1:0]     valid_in;
  logic           stop;
  logic           retire_valid;
  preg_t          retire_preg;
  instr_info_t    instr_out [2];
  rename_result_t result [2];
  jmp_relation_e  jmp_relation;
  logic           stall_out;

  // Reference model state.
  preg_t          m_map [`ARCH_REGS];
  preg_t          m_free [$];
  preg_t          m_retire [$];
  logic [1:0]     m_q_valid;
  logic [1:0]     m_q_rename;
  regs_t          m_q_regs [2];
  jmp_relation_e  m_rel_q;
  instr_info_t    m_info_q [2];
  logic           m_stalled;
  int             m_avail;
  rename_result_t exp_res [2];
  jmp_relation_e  exp_rel;
  instr_info_t    exp_info [2];
  logic           exp_stall;
  logic           unknown_in;
  logic [1:0]     rename_in;
  int             mismatches;
  int             failures;
  logic           saw_exhaust;
  string          test_name;

  always #4 global_bus = ~global_bus;

  rename_unit dut_i (
    .global_bus   (global_bus),
    .rst          (rst),
    .instr_in     (instr_in),
    .valid_in     (valid_in),
    .stop         (stop),
    .retire_valid (retire_valid),
    .retire_preg  (retire_preg),
    .instr_out    (instr_out),
    .result       (result),
    .jmp_relation (jmp_relation),
    .stall_out    (stall_out)
  );

  assign unknown_in = (instr_in[0].instr_name == UNKNOWN) || (instr_in[1].instr_name == UNKNOWN);
  assign rename_in[0] = valid_in[0] && !unknown_in && instr_in[0].flags.writes &&
                        (instr_in[0].regs.rd != '0);
  assign rename_in[1] = valid_in[1] && !unknown_in && instr_in[1].flags.writes &&
                        (instr_in[1].regs.rd != '0);

  // In-flight renames plus the incoming pair must fit in the free list.
  assign exp_stall = stop || (m_avail < int'(m_q_rename[0]) + int'(m_q_rename[1]) +
                                        int'(rename_in[0]) + int'(rename_in[1]));

  function automatic string show(input rename_result_t r);
    return $sformatf("v=%b ps_1=%0d ps_2=%0d pd=%0d old_pd=%0d",
                     r.valid, r.ps_1, r.ps_2, r.pd, r.old_pd);
  endfunction

  function automatic string rel_name(input jmp_relation_e r);
    return r.name();
  endfunction

  for (genvar i = 0; i < 2; i++) begin : gen_check
    a_result: assert property (@(posedge global_bus) disable iff (rst) result[i] == exp_res[i])
      else begin
        mismatches++;
        $display("MISMATCH %s lane %0d result: expected %s actual %s", test_name, i,
                 show($sampled(exp_res[i])), show($sampled(result[i])));
      end

    a_instr_out: assert property (@(posedge global_bus) disable iff (rst)
        instr_out[i] == exp_info[i])
      else begin
        mismatches++;
        $display("MISMATCH %s lane %0d instr_out: expected %h actual %h", test_name, i,
                 $sampled(exp_info[i]), $sampled(instr_out[i]));
      end
  end

  a_relation: assert property (@(posedge global_bus) disable iff (rst) jmp_relation == exp_rel)
    else begin
      mismatches++;
      $display("MISMATCH %s jmp_relation: expected %s actual %s", test_name,
               rel_name($sampled(exp_rel)), rel_name($sampled(jmp_relation)));
    end

  a_stall: assert property (@(posedge global_bus) disable iff (rst) stall_out == exp_stall)
    else begin
      mismatches++;
      $display("MISMATCH %s stall_out: expected %b actual %b", test_name,
               $sampled(exp_stall), $sampled(stall_out));
    end

  // One clock edge of the model, using the inputs seen at that edge.
  task automatic model_step();
    logic stall;
    stall = exp_stall;
    // Table stage works lane 0 first, so lane 1 sees its new mapping.
    for (int i = 0; i < 2; i++) begin
      if (m_q_valid[i]) begin
        exp_res[i].valid  = 1'b1;
        exp_res[i].ps_1   = m_map[m_q_regs[i].rs_1];
        exp_res[i].ps_2   = m_map[m_q_regs[i].rs_2];
        exp_res[i].old_pd = m_map[m_q_regs[i].rd];
        exp_res[i].pd     = m_map[m_q_regs[i].rd];
        if (m_q_rename[i]) begin
          exp_res[i].pd = m_free.pop_front();
          m_map[m_q_regs[i].rd] = exp_res[i].pd;
          m_retire.push_back(exp_res[i].old_pd);
        end
      end else begin
        exp_res[i].valid = 1'b0;
      end
    end
    if (retire_valid) begin
      m_free.push_back(retire_preg);
    end
    m_avail = m_free.size();
    exp_rel = m_rel_q;
    // Instruction info passes two registers, the first held while stalled.
    exp_info[0] = m_info_q[0];
    exp_info[1] = m_info_q[1];
    if (stall) begin
      m_q_valid  = 2'b00;
      m_q_rename = 2'b00;
    end else begin
      m_q_valid   = valid_in & {2{!unknown_in}};
      m_q_rename  = rename_in;
      m_q_regs[0] = instr_in[0].regs;
      m_q_regs[1] = instr_in[1].regs;
      m_info_q[0] = instr_in[0];
      m_info_q[1] = instr_in[1];
      m_rel_q     = unknown_in ? ERROR :
                    instr_in[0].flags.jumps ? (instr_in[1].flags.jumps ? JJ : JN) :
                                              (instr_in[1].flags.jumps ? NJ : NN);
    end
    m_stalled = stall;
  endtask

  task automatic make_pair(input mode_e mode);
    instr_info_t ins [2];
    for (int i = 0; i < 2; i++) begin
      ins[i].address      = $urandom;
      ins[i].immediate    = $urandom;
      ins[i].instr_name   = instr_name_e'($urandom_range(0, 13));
      ins[i].regs.rs_1    = areg_t'($urandom_range(0, 31));
      ins[i].regs.rs_2    = areg_t'($urandom_range(0, 31));
      ins[i].regs.rd      = areg_t'($urandom_range(0, 31));
      ins[i].flags.jumps  = 1'($urandom_range(0, 1));
      ins[i].flags.writes = (mode inside {M_RENAME, M_DEP}) || ($urandom_range(0, 1) == 1);
    end
    if (mode == M_RENAME && $urandom_range(0, 5) == 0) begin
      ins[1].regs.rd = '0;
    end
    if (mode == M_DEP) begin
      ins[1].regs.rs_1 = ins[0].regs.rd;
      if ($urandom_range(0, 1) == 1) begin
        ins[1].regs.rs_2 = ins[0].regs.rd;
      end
      if ($urandom_range(0, 3) == 0) begin
        ins[1].regs.rd = ins[0].regs.rd;
      end
    end
    if (mode inside {M_JUMP, M_RANDOM} && $urandom_range(0, 7) == 0) begin
      ins[$urandom_range(0, 1)].instr_name = UNKNOWN;
    end
    instr_in[0] <= ins[0];
    instr_in[1] <= ins[1];
    valid_in    <= (mode == M_RANDOM) ? 2'($urandom_range(0, 3)) : 2'b11;
  endtask

  // A stalled pair is held until the stage takes it.
  task automatic step(input mode_e mode, input logic stp, input logic retire_ok);
    @(posedge global_bus);
    model_step();
    if (!m_stalled) begin
      make_pair(mode);
    end
    stop <= stp;
    if (retire_ok && m_retire.size() > 0) begin
      retire_valid <= 1'b1;
      retire_preg  <= m_retire.pop_front();
    end else begin
      retire_valid <= 1'b0;
    end
  endtask

  initial begin
    void'($urandom(32'h1d9698b4));
    rst          = 1'b1;
    stop         = 1'b0;
    valid_in     = 2'b00;
    retire_valid = 1'b0;
    retire_preg  = '0;
    instr_in[0]  = '0;
    instr_in[1]  = '0;
    mismatches   = 0;
    failures     = 0;
    saw_exhaust  = 1'b0;
    test_name    = "reset";
    for (int i = 0; i < `ARCH_REGS; i++) begin
      m_map[i] = preg_t'(i);
      m_free.push_back(preg_t'(`ARCH_REGS + i));
    end
    m_avail     = m_free.size();
    m_q_valid   = 2'b00;
    m_q_rename  = 2'b00;
    m_rel_q     = ERROR;
    exp_rel     = ERROR;
    exp_res[0]  = '0;
    exp_res[1]  = '0;
    m_info_q[0] = '0;
    m_info_q[1] = '0;
    exp_info[0] = '0;
    exp_info[1] = '0;
    repeat (3) @(posedge global_bus);
    rst <= 1'b0;

    test_name = "rename";
    repeat (RENAME_N) step(M_RENAME, 1'b0, 1'b0);
    test_name = "exhaust";
    repeat (EXHAUST_N) begin
      step(M_RENAME, 1'b0, 1'b0);
      if (stall_out) begin
        saw_exhaust = 1'b1;
      end
    end
    a_exhaust: assert (saw_exhaust)
      else begin
        failures++;
        $display("stall_out never rose after %0d cycles without retire", EXHAUST_N);
      end
    test_name = "recycle";
    repeat (RECYCLE_N) step(M_RENAME, 1'b0, 1'b1);
    test_name = "dependency";
    repeat (DEP_N) step(M_DEP, 1'b0, $urandom_range(0, 3) != 0);
    test_name = "jump";
    repeat (JUMP_N) step(M_JUMP, 1'b0, $urandom_range(0, 3) != 0);
    test_name = "stall";
    repeat (STALL_N) step(M_RANDOM, $urandom_range(0, 2) == 0, $urandom_range(0, 3) != 0);
    test_name = "random";
    repeat (RANDOM_N) step(M_RANDOM, $urandom_range(0, 7) == 0, $urandom_range(0, 2) != 0);
    test_name = "drain";
    repeat (3) step(M_RANDOM, 1'b0, 1'b0);
    @(negedge global_bus);

    $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge global_bus);
    $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- design/rename_unit.sv
`include "rename_params.svh"

module rename_unit import rename_pkg::*; (
  input  logic           global_bus,
  input  logic           rst,
  input  instr_info_t    instr_in [2],
  input  logic [1:0]     valid_in,
  input  logic           stop,
  input  logic           retire_valid,
  input  preg_t          retire_preg,
  output instr_info_t    instr_out [2],
  output rename_result_t result [2],
  output jmp_relation_e  jmp_relation,
  output logic           stall_out
);

  logic [1:0]          alloc_req;
  preg_t               alloc_preg [2];
  logic [`COUNT_W-1:0] avail_count;

  reg_query_if query_if [2] ();

  renamer renamer_i (
    .global_bus   (global_bus),
    .rst          (rst),
    .instr_in     (instr_in),
    .valid_in     (valid_in),
    .stop         (stop),
    .avail_count  (avail_count),
    .query        (query_if),
    .instr_out    (instr_out),
    .jmp_relation (jmp_relation),
    .stall_out    (stall_out)
  );

  rename_table rename_table_i (
    .global_bus (global_bus),
    .rst        (rst),
    .query      (query_if),
    .alloc_req  (alloc_req),
    .alloc_preg (alloc_preg)
  );

  free_list free_list_i (
    .global_bus    (global_bus),
    .rst           (rst),
    .alloc_req     (alloc_req),
    .alloc_preg    (alloc_preg),
    .avail_count   (avail_count),
    .release_valid (retire_valid),
    .release_preg  (retire_preg)
  );

  assign result[0] = query_if[0].result;
  assign result[1] = query_if[1].result;

endmodule

//--- renamer/free_list.sv
`include "rename_params.svh"

module free_list import rename_pkg::*; (
  input  logic                global_bus,
  input  logic                rst,
  input  logic [1:0]          alloc_req,
  output preg_t               alloc_preg [2],
  output logic [`COUNT_W-1:0] avail_count,
  input  logic                release_valid,
  input  preg_t               release_preg
);

  localparam int PTR_W = $clog2(`FREE_REGS);
  localparam int CW    = `COUNT_W;

  preg_t            queue [`FREE_REGS];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CW-1:0]    count;
  logic [1:0]       num_alloc;

  assign num_alloc = {1'b0, alloc_req[0]} + {1'b0, alloc_req[1]};

  // Lane 1 takes the entry after whatever lane 0 takes.
  assign alloc_preg[0] = queue[head];
  assign alloc_preg[1] = queue[head + PTR_W'(alloc_req[0])];
  assign avail_count   = count;

  always_ff @(posedge global_bus) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= CW'(`FREE_REGS);
    end else begin
      head  <= head + PTR_W'(num_alloc);
      count <= count - CW'(num_alloc) + CW'(release_valid);
      if (release_valid) begin
        tail <= tail + 1'b1;
      end
    end
  end

  // Starts full with the registers above the identity map.
  always_ff @(posedge global_bus) begin
    if (rst) begin
      for (int i = 0; i < `FREE_REGS; i++) begin
        queue[i] <= preg_t'(`PHYS_REGS - `FREE_REGS + i);
      end
    end else if (release_valid) begin
      queue[tail] <= release_preg;
    end
  end

  a_alloc_covered: assert property (@(posedge global_bus) disable iff (rst)
    CW'(num_alloc) <= count);

  a_no_overflow: assert property (@(posedge global_bus) disable iff (rst)
    release_valid && (num_alloc == 2'd0) |-> count < CW'(`FREE_REGS));

endmodule

//--- renamer/rename_table.sv
`include "rename_params.svh"

module rename_table import rename_pkg::*; (
  input  logic            global_bus,
  input  logic            rst,
  reg_query_if.alias_table query [2],
  output logic [1:0]      alloc_req,
  input  preg_t           alloc_preg [2]
);

  preg_t          map [`ARCH_REGS];
  logic [1:0]     q_valid;
  logic [1:0]     q_rename;
  areg_t          q_rs_1 [2];
  areg_t          q_rs_2 [2];
  areg_t          q_rd [2];
  logic           hit_rs_1;
  logic           hit_rs_2;
  logic           hit_rd;
  rename_result_t res_d [2];

  for (genvar i = 0; i < 2; i++) begin : gen_unpack
    assign q_valid[i]  = query[i].valid;
    assign q_rename[i] = query[i].rename;
    assign q_rs_1[i]   = query[i].rs_1;
    assign q_rs_2[i]   = query[i].rs_2;
    assign q_rd[i]     = query[i].rd;
  end

  assign alloc_req = q_rename;

  // Lane 1 reads through lane 0's new destination.
  assign hit_rs_1 = q_rename[0] && (q_rs_1[1] == q_rd[0]);
  assign hit_rs_2 = q_rename[0] && (q_rs_2[1] == q_rd[0]);
  assign hit_rd   = q_rename[0] && (q_rd[1] == q_rd[0]);

  always_comb begin
    res_d[0].valid  = q_valid[0];
    res_d[0].ps_1   = map[q_rs_1[0]];
    res_d[0].ps_2   = map[q_rs_2[0]];
    res_d[0].old_pd = map[q_rd[0]];
    res_d[0].pd     = q_rename[0] ? alloc_preg[0] : map[q_rd[0]];

    res_d[1].valid  = q_valid[1];
    res_d[1].ps_1   = hit_rs_1 ? alloc_preg[0] : map[q_rs_1[1]];
    res_d[1].ps_2   = hit_rs_2 ? alloc_preg[0] : map[q_rs_2[1]];
    res_d[1].old_pd = hit_rd ? alloc_preg[0] : map[q_rd[1]];
    res_d[1].pd     = q_rename[1] ? alloc_preg[1] : res_d[1].old_pd;
  end

  // Lane 1 is written last, so it wins on a shared rd.
  always_ff @(posedge global_bus) begin
    if (rst) begin
      for (int i = 0; i < `ARCH_REGS; i++) begin
        map[i] <= preg_t'(i);
      end
    end else begin
      if (q_rename[0]) begin
        map[q_rd[0]] <= alloc_preg[0];
      end
      if (q_rename[1]) begin
        map[q_rd[1]] <= alloc_preg[1];
      end
    end
  end

  for (genvar i = 0; i < 2; i++) begin : gen_result
    always_ff @(posedge global_bus) begin
      if (rst) begin
        query[i].result <= '0;
      end else if (q_valid[i]) begin
        query[i].result <= res_d[i];
      end else begin
        query[i].result.valid <= 1'b0;
      end
    end

    // Keeps register 0 mapped to physical register 0.
    a_rename_legal: assert property (@(posedge global_bus) disable iff (rst)
      q_rename[i] |-> q_valid[i] && (q_rd[i] != '0));
  end

endmodule

//--- renamer/renamer.sv
`include "rename_params.svh"

module renamer import rename_pkg::*; (
  input  logic                global_bus,
  input  logic                rst,
  input  instr_info_t         instr_in [2],
  input  logic [1:0]          valid_in,
  input  logic                stop,
  input  logic [`COUNT_W-1:0] avail_count,
  reg_query_if.renamer        query [2],
  output instr_info_t         instr_out [2],
  output jmp_relation_e       jmp_relation,
  output logic                stall_out
);

  localparam int CW = `COUNT_W;

  logic          unknown;
  logic [1:0]    rename_in;
  logic [1:0]    pending;
  logic [CW-1:0] demand;
  logic          stall;
  instr_info_t   info_q [2];
  jmp_relation_e relation_q;

  assign unknown = (instr_in[0].instr_name == UNKNOWN) ||
                   (instr_in[1].instr_name == UNKNOWN);

  // Renames already in the query registers are taken at the next edge.
  assign demand = CW'(pending[0]) + CW'(pending[1]) +
                  CW'(rename_in[0]) + CW'(rename_in[1]);

  assign stall     = stop || (avail_count < demand);
  assign stall_out = stall;

  for (genvar i = 0; i < 2; i++) begin : gen_lane
    assign rename_in[i] = valid_in[i] && !unknown && instr_in[i].flags.writes &&
                          (instr_in[i].regs.rd != '0);
    assign pending[i]   = query[i].rename;

    always_ff @(posedge global_bus) begin
      if (rst || stall) begin
        query[i].valid  <= 1'b0;
        query[i].rename <= 1'b0;
      end else begin
        query[i].valid  <= valid_in[i] && !unknown;
        query[i].rename <= rename_in[i];
      end
    end

    // Operand fields hold while stalled.
    always_ff @(posedge global_bus) begin
      if (!stall) begin
        query[i].rs_1 <= instr_in[i].regs.rs_1;
        query[i].rs_2 <= instr_in[i].regs.rs_2;
        query[i].rd   <= instr_in[i].regs.rd;
        info_q[i]     <= instr_in[i];
      end
      instr_out[i] <= info_q[i];
    end
  end

  // Relation moves with the queries, then lines up with the table result.
  always_ff @(posedge global_bus) begin
    if (rst) begin
      relation_q   <= ERROR;
      jmp_relation <= ERROR;
    end else begin
      if (!stall) begin
        if (unknown) begin
          relation_q <= ERROR;
        end else begin
          case ({instr_in[0].flags.jumps, instr_in[1].flags.jumps})
            2'b00:   relation_q <= NN;
            2'b01:   relation_q <= NJ;
            2'b10:   relation_q <= JN;
            2'b11:   relation_q <= JJ;
            default: relation_q <= ERROR;
          endcase
        end
      end
      jmp_relation <= relation_q;
    end
  end

  // A stalled cycle takes nothing from the free list one edge later.
  a_no_rename_in_stall: assert property (@(posedge global_bus) disable iff (rst)
    stall |=> ##1 (avail_count >= $past(avail_count)));

  // Free list must still cover what is in flight.
  a_renames_covered: assert property (@(posedge global_bus) disable iff (rst)
    avail_count >= CW'(pending[0]) + CW'(pending[1]));

endmodule

//--- common/reg_query_if.sv
interface reg_query_if import rename_pkg::*; ();

  logic           valid;
  logic           rename;
  areg_t          rs_1;
  areg_t          rs_2;
  areg_t          rd;
  rename_result_t result;

  modport renamer (
    output valid,
    output rename,
    output rs_1,
    output rs_2,
    output rd,
    input  result
  );

  modport alias_table (
    input  valid,
    input  rename,
    input  rs_1,
    input  rs_2,
    input  rd,
    output result
  );

endinterface

//--- common/rename_pkg.sv
`include "rename_params.svh"

package rename_pkg;

  typedef logic [$clog2(`ARCH_REGS)-1:0] areg_t;
  typedef logic [$clog2(`PHYS_REGS)-1:0] preg_t;

  typedef enum logic [3:0] {
    NOP,
    ADD,
    ADDI,
    SUB,
    AND,
    OR,
    XOR,
    LUI,
    LW,
    SW,
    BEQ,
    BNE,
    JAL,
    JALR,
    UNKNOWN
  } instr_name_e;

  typedef struct packed {
    areg_t rs_1;
    areg_t rs_2;
    areg_t rd;
  } regs_t;

  typedef struct packed {
    logic jumps;
    logic writes;
  } flags_t;

  typedef struct packed {
    logic [`XLEN-1:0] address;
    logic [`XLEN-1:0] immediate;
    instr_name_e      instr_name;
    regs_t            regs;
    flags_t           flags;
  } instr_info_t;

  // First letter is lane 0, second is lane 1.
  typedef enum logic [2:0] {NN, NJ, JN, JJ, ERROR} jmp_relation_e;

  typedef struct packed {
    logic  valid;
    preg_t ps_1;
    preg_t ps_2;
    preg_t pd;
    preg_t old_pd;
  } rename_result_t;

endpackage

//--- common/rename_params.svh
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Data path width.
`define XLEN 32

// Register file sizes.
`define ARCH_REGS 32
`define PHYS_REGS 64

// Registers that start out free, above the identity mapping.
`define FREE_REGS (`PHYS_REGS - `ARCH_REGS)

// Free count width, wide enough to hold a full list.
`define COUNT_W ($clog2(`PHYS_REGS) + 1)

`endif
